// ==== include/i2cMaster_params.svh ====
`ifndef I2C_MASTER_PARAMS_SVH
`define I2C_MASTER_PARAMS_SVH

// FSM_Clk cycles per quarter of an I2C bit
// Four quarters make one SCL period
// Small value keeps simulation short
`define I2C_QUARTER_DIV 4

// APB byte offsets of the register map
// CTRL bit 0 starts a transaction, bit 1 selects read
`define REG_CTRL 8'h00

// STATUS bit 0 busy, bit 1 done, bit 2 ackError
`define REG_STATUS 8'h04

`define REG_DEVADDR 8'h08
`define REG_REGADDR 8'h0C
`define REG_WDATA 8'h10

// Byte returned by the last read transaction
`define REG_RDATA 8'h14

`endif

// ==== rtl/i2cPkg.sv ====
`default_nettype none

package i2cPkg;

    // One byte on the bus, data or address
    typedef logic [7:0] byte_t;

    // APB byte address
    typedef logic [7:0] apbAddr_t;

    // Quarter of the current I2C bit
    // SCL is low, high, high, low across the four
    typedef enum logic [1:0] {
        lowSet     = 2'd0,
        riseHigh   = 2'd1,
        highSample = 2'd2,
        fallLow    = 2'd3
    } phase_t;

    // Transaction sequencer states
    // Each state lasts a whole number of bits
    typedef enum logic [3:0] {
        idle       = 4'd0,
        start      = 4'd1,
        sendByte   = 4'd2,
        getAck     = 4'd3,
        restart    = 4'd4,
        recvByte   = 4'd5,
        masterNack = 4'd6,
        stop       = 4'd7
    } seqState_t;

endpackage

`default_nettype wire

// ==== rtl/apbRegs.sv ====
`default_nettype none
`include "i2cMaster_params.svh"

module apbRegs (
    input  logic             FSM_Clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  i2cPkg::apbAddr_t paddr,
    input  logic [31:0]      pwdata,
    input  logic             busy,
    input  logic             donePulse,
    input  logic             ackError,
    input  i2cPkg::byte_t    rxByte,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             startPulse,
    output logic             readMode,
    output logic [6:0]       devAddr,
    output i2cPkg::byte_t    regAddr,
    output i2cPkg::byte_t    writeByte
);
    import i2cPkg::*;

    logic  writeAccess;
    logic  startReq;
    logic  busyView;
    logic  doneFlag;
    logic  ackErrFlag;
    byte_t readData;

    assign writeAccess = psel && penable && pwrite;
    // Covers the cycle between the start access and the sequencer leaving idle
    assign busyView = busy || startPulse;
    assign startReq = writeAccess && (paddr == `REG_CTRL) && pwdata[0];

    // No wait states
    assign pready = 1'b1;
    assign pslverr = startReq && busyView;

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            startPulse <= 1'b0;
            readMode   <= 1'b0;
            devAddr    <= '0;
            regAddr    <= '0;
            writeByte  <= '0;
            readData   <= '0;
            doneFlag   <= 1'b0;
            ackErrFlag <= 1'b0;
        end else begin
            startPulse <= startReq && !busyView;
            if (writeAccess) begin
                case (paddr)
                    `REG_CTRL: begin
                        // Whole CTRL write is dropped while a transfer runs
                        if (!busyView) begin
                            readMode <= pwdata[1];
                        end
                    end
                    `REG_DEVADDR: devAddr <= pwdata[6:0];
                    `REG_REGADDR: regAddr <= pwdata[7:0];
                    `REG_WDATA:   writeByte <= pwdata[7:0];
                    default: ;
                endcase
            end
            // Sticky status, cleared by the next accepted start
            if (startReq && !busyView) begin
                doneFlag   <= 1'b0;
                ackErrFlag <= 1'b0;
            end else if (donePulse) begin
                doneFlag   <= 1'b1;
                ackErrFlag <= ackError;
                if (readMode) begin
                    readData <= rxByte;
                end
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            `REG_CTRL:    prdata = {30'd0, readMode, 1'b0};
            `REG_STATUS:  prdata = {29'd0, ackErrFlag, doneFlag, busyView};
            `REG_DEVADDR: prdata = {25'd0, devAddr};
            `REG_REGADDR: prdata = {24'd0, regAddr};
            `REG_WDATA:   prdata = {24'd0, writeByte};
            `REG_RDATA:   prdata = {24'd0, readData};
            default: ;
        endcase
    end

    // Access phase only ever follows a selected setup phase
    assert property (@(posedge FSM_Clk) disable iff (reset) penable |-> psel)
        else $error("APB penable high without psel");

endmodule

`default_nettype wire

// ==== rtl/bitTimer.sv ====
`default_nettype none
`include "i2cMaster_params.svh"

module bitTimer (
    input  logic            FSM_Clk,
    input  logic            reset,
    input  logic            timerRun,
    output logic            quarterTick,
    output i2cPkg::phase_t  phase
);
    import i2cPkg::*;

    localparam logic [9:0] quarterDiv = `I2C_QUARTER_DIV;

    logic [9:0] divCount;

    // Tick lands quarterDiv cycles after timerRun rises
    always_ff @(posedge FSM_Clk) begin
        if (reset || !timerRun) begin
            divCount    <= quarterDiv - 10'd1;
            quarterTick <= 1'b0;
            phase       <= lowSet;
        end else begin
            quarterTick <= (divCount == '0);
            if (divCount == '0) begin
                divCount <= quarterDiv - 10'd1;
            end else begin
                divCount <= divCount - 10'd1;
            end
            // Phase wraps from fallLow back to lowSet
            if (quarterTick) begin
                phase <= phase_t'(phase + 2'd1);
            end
        end
    end

    // Single-cycle tick relies on a divisor of at least two
    assert property (@(posedge FSM_Clk) disable iff (reset) quarterTick |=> !quarterTick)
        else $error("quarterTick held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/byteShifter.sv ====
`default_nettype none

module byteShifter (
    input  logic          FSM_Clk,
    input  logic          reset,
    input  logic          load,
    input  i2cPkg::byte_t loadByte,
    input  logic          shift,
    input  logic          sample,
    input  logic          sdaIn,
    output logic          txBit,
    output i2cPkg::byte_t rxByte
);
    import i2cPkg::*;

    // Shared by transmit and receive, MSB first on the wire
    byte_t shiftReg;

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            shiftReg <= '0;
        end else if (load) begin
            shiftReg <= loadByte;
        end else if (shift) begin
            // Next bit moves into the MSB
            shiftReg <= {shiftReg[6:0], 1'b0};
        end else if (sample) begin
            // Eight samples replace the whole byte
            shiftReg <= {shiftReg[6:0], sdaIn};
        end
    end

    assign txBit = shiftReg[7];
    assign rxByte = shiftReg;

endmodule

`default_nettype wire

// ==== rtl/i2cSequencer.sv ====
`default_nettype none

module i2cSequencer (
    input  logic           FSM_Clk,
    input  logic           reset,
    input  logic           startPulse,
    input  logic           readMode,
    input  logic [6:0]     devAddr,
    input  i2cPkg::byte_t  regAddr,
    input  i2cPkg::byte_t  writeByte,
    input  logic           quarterTick,
    input  i2cPkg::phase_t phase,
    input  logic           txBit,
    input  logic           sdaIn,
    output logic           timerRun,
    output logic           load,
    output i2cPkg::byte_t  loadByte,
    output logic           shift,
    output logic           sample,
    output logic           scl,
    output logic           sdaDriveLow,
    output logic           busy,
    output logic           donePulse,
    output logic           ackError
);
    import i2cPkg::*;

    // Which byte of the frame is on the bus
    typedef enum logic [1:0] {
        selAddrWr,
        selReg,
        selData,
        selAddrRd
    } byteSel_t;

    seqState_t state;
    seqState_t nextState;
    byteSel_t  byteSel;
    logic [2:0] bitCnt;
    logic      modeRead;
    logic      lastQuarter;
    logic      highPhase;
    logic      condState;

    assign lastQuarter = quarterTick && (phase == fallLow);
    assign highPhase = (phase == riseHigh) || (phase == highSample);
    assign condState = (state == start) || (state == restart) || (state == stop);
    assign busy = (state != idle);
    assign donePulse = lastQuarter && (state == stop);

    always_comb begin
        nextState = state;
        load = 1'b0;
        loadByte = '0;
        shift = 1'b0;
        sample = 1'b0;
        case (state)
            idle: if (startPulse) nextState = start;
            start: begin
                if (lastQuarter) begin
                    nextState = sendByte;
                    load = 1'b1;
                    loadByte = {devAddr, 1'b0};
                end
            end
            sendByte: begin
                if (lastQuarter) begin
                    if (bitCnt == 3'd0) nextState = getAck;
                    else shift = 1'b1;
                end
            end
            getAck: begin
                if (lastQuarter) begin
                    // Missing acknowledge cuts straight to STOP
                    if (ackError) begin
                        nextState = stop;
                    end else begin
                        case (byteSel)
                            selAddrWr: begin
                                nextState = sendByte;
                                load = 1'b1;
                                loadByte = regAddr;
                            end
                            selReg: begin
                                if (modeRead) begin
                                    nextState = restart;
                                end else begin
                                    nextState = sendByte;
                                    load = 1'b1;
                                    loadByte = writeByte;
                                end
                            end
                            selData: nextState = stop;
                            default: nextState = recvByte;
                        endcase
                    end
                end
            end
            restart: begin
                if (lastQuarter) begin
                    nextState = sendByte;
                    load = 1'b1;
                    loadByte = {devAddr, 1'b1};
                end
            end
            recvByte: begin
                sample = quarterTick && (phase == highSample);
                if (lastQuarter && bitCnt == 3'd0) nextState = masterNack;
            end
            masterNack: if (lastQuarter) nextState = stop;
            default: if (lastQuarter) nextState = idle;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state    <= idle;
            byteSel  <= selAddrWr;
            bitCnt   <= 3'd7;
            modeRead <= 1'b0;
            ackError <= 1'b0;
            timerRun <= 1'b0;
        end else begin
            state    <= nextState;
            timerRun <= (nextState != idle);
            if (state == idle && startPulse) begin
                modeRead <= readMode;
                ackError <= 1'b0;
                byteSel  <= selAddrWr;
            end
            if (lastQuarter) begin
                if ((state == sendByte || state == recvByte) && bitCnt != 3'd0) begin
                    bitCnt <= bitCnt - 3'd1;
                end else begin
                    bitCnt <= 3'd7;
                end
            end
            if (state == getAck && quarterTick && phase == highSample && sdaIn) begin
                ackError <= 1'b1;
            end
            if (state == getAck && lastQuarter) begin
                if (byteSel == selAddrWr) byteSel <= selReg;
                else if (byteSel == selReg) byteSel <= modeRead ? selAddrRd : selData;
            end
        end
    end

    // Line levels per state and quarter
    always_comb begin
        case (state)
            idle: begin
                scl = 1'b1;
                sdaDriveLow = 1'b0;
            end
            start: begin
                scl = (phase != fallLow);
                sdaDriveLow = (phase != lowSet);
            end
            sendByte: begin
                scl = highPhase;
                sdaDriveLow = !txBit;
            end
            restart: begin
                scl = highPhase;
                sdaDriveLow = (phase == highSample) || (phase == fallLow);
            end
            stop: begin
                // SCL stays high once released so SDA rises last
                scl = (phase != lowSet);
                sdaDriveLow = (phase == lowSet) || (phase == riseHigh);
            end
            default: begin
                scl = highPhase;
                sdaDriveLow = 1'b0;
            end
        endcase
    end

    // Data bits only move while SCL is low
    assert property (@(posedge FSM_Clk) disable iff (reset)
        (scl && $past(scl) && !condState && !$past(condState)) |-> $stable(sdaDriveLow))
        else $error("SDA changed with SCL high in state %s", state.name());

endmodule

`default_nettype wire

// ==== rtl/i2cMasterTop.sv ====
`default_nettype none

module i2cMasterTop (
    input  logic             FSM_Clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  i2cPkg::apbAddr_t paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             scl,
    output logic             sdaDriveLow,
    input  logic             sdaIn
);
    import i2cPkg::*;

    logic       startPulse;
    logic       readMode;
    logic [6:0] devAddr;
    byte_t      regAddr;
    byte_t      writeByte;
    logic       busy;
    logic       donePulse;
    logic       ackError;
    byte_t      rxByte;
    logic       timerRun;
    logic       quarterTick;
    phase_t     phase;
    logic       load;
    byte_t      loadByte;
    logic       shift;
    logic       sample;
    logic       txBit;

    apbRegs i_apbRegs (
        .FSM_Clk(FSM_Clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .busy(busy), .donePulse(donePulse), .ackError(ackError), .rxByte(rxByte),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .startPulse(startPulse), .readMode(readMode), .devAddr(devAddr),
        .regAddr(regAddr), .writeByte(writeByte)
    );

    bitTimer i_bitTimer (
        .FSM_Clk(FSM_Clk), .reset(reset), .timerRun(timerRun),
        .quarterTick(quarterTick), .phase(phase)
    );

    byteShifter i_byteShifter (
        .FSM_Clk(FSM_Clk), .reset(reset),
        .load(load), .loadByte(loadByte), .shift(shift), .sample(sample), .sdaIn(sdaIn),
        .txBit(txBit), .rxByte(rxByte)
    );

    i2cSequencer i_i2cSequencer (
        .FSM_Clk(FSM_Clk), .reset(reset),
        .startPulse(startPulse), .readMode(readMode), .devAddr(devAddr),
        .regAddr(regAddr), .writeByte(writeByte),
        .quarterTick(quarterTick), .phase(phase), .txBit(txBit), .sdaIn(sdaIn),
        .timerRun(timerRun), .load(load), .loadByte(loadByte), .shift(shift),
        .sample(sample), .scl(scl), .sdaDriveLow(sdaDriveLow),
        .busy(busy), .donePulse(donePulse), .ackError(ackError)
    );

endmodule

`default_nettype wire

// ==== verification/i2cSlaveModel.sv ====
`default_nettype none

module i2cSlaveModel #(
    parameter logic [6:0] targetAddr = 7'h48
) (
    input  logic       FSM_Clk,
    input  logic       reset,
    input  logic       scl,
    input  logic       sda,
    output logic       sdaDriveLow,
    input  logic       loadEn,
    input  logic [7:0] loadAddr,
    input  logic [7:0] loadData,
    input  logic [7:0] peekAddr,
    output logic [7:0] peekData
);

    typedef enum logic [2:0] {mIdle, mAddr, mReg, mWrite, mRead} mode_t;

    mode_t      mode;
    logic       sclPrev;
    logic       sdaPrev;
    logic [3:0] bitCount;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [7:0] regPtr;
    logic [7:0] mem [0:255];

    assign peekData = mem[peekAddr];

    // Bus is oversampled on FSM_Clk, edges seen one cycle late
    always @(posedge FSM_Clk) begin
        if (reset) begin
            mode        <= mIdle;
            sclPrev     <= 1'b1;
            sdaPrev     <= 1'b1;
            bitCount    <= 4'd0;
            shiftIn     <= 8'd0;
            txByte      <= 8'd0;
            regPtr      <= 8'd0;
            sdaDriveLow <= 1'b0;
        end else begin
            sclPrev <= scl;
            sdaPrev <= sda;
            if (loadEn) begin
                mem[loadAddr] <= loadData;
            end
            if (sclPrev && scl && sdaPrev && !sda) begin
                // START or repeated START
                mode        <= mAddr;
                bitCount    <= 4'd0;
                sdaDriveLow <= 1'b0;
            end else if (sclPrev && scl && !sdaPrev && sda) begin
                mode        <= mIdle;
                sdaDriveLow <= 1'b0;
            end else if (mode != mIdle && !sclPrev && scl) begin
                bitCount <= bitCount + 4'd1;
                if (bitCount < 4'd8) begin
                    shiftIn <= {shiftIn[6:0], sda};
                end else if (mode == mRead && sda) begin
                    // Master NACK ends the read
                    mode <= mIdle;
                end
            end else if (mode != mIdle && sclPrev && !scl) begin
                if (bitCount == 4'd8) begin
                    sdaDriveLow <= (mode != mRead);
                    case (mode)
                        mAddr: begin
                            if (shiftIn[7:1] != targetAddr) begin
                                mode        <= mIdle;
                                sdaDriveLow <= 1'b0;
                            end else begin
                                mode <= shiftIn[0] ? mRead : mReg;
                            end
                        end
                        mReg: begin
                            regPtr <= shiftIn;
                            mode   <= mWrite;
                        end
                        mWrite: begin
                            mem[regPtr] <= shiftIn;
                            regPtr      <= regPtr + 8'd1;
                        end
                        default: ;
                    endcase
                end else if (bitCount == 4'd9) begin
                    bitCount    <= 4'd0;
                    sdaDriveLow <= (mode == mRead) && !mem[regPtr][7];
                    if (mode == mRead) begin
                        txByte <= {mem[regPtr][6:0], 1'b0};
                        regPtr <= regPtr + 8'd1;
                    end
                end else if (mode == mRead) begin
                    sdaDriveLow <= !txByte[7];
                    txByte      <= {txByte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tbI2cMaster.sv ====
`default_nettype none
`include "i2cMaster_params.svh"

module tbI2cMaster;
    import i2cPkg::*;

    localparam int apbTimeout = 16;
    localparam int doneTimeout = 1000;

    logic        FSM_Clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apbAddr_t    paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        masterLow;
    logic        slaveLow;
    wire         sda;
    logic        loadEn;
    byte_t       loadAddr;
    byte_t       loadData;
    byte_t       peekAddr;
    byte_t       peekData;

    byte_t       expMem [0:255];
    string       nameQ[$];
    logic [31:0] expQ[$];
    logic [31:0] actQ[$];
    int          checkCount;
    int          errorCount;
    int          testErrors;
    int          seed;

    // Open-drain bus
    assign sda = !(masterLow || slaveLow);

    i2cMasterTop i_i2cMasterTop (
        .FSM_Clk(FSM_Clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .scl(scl), .sdaDriveLow(masterLow), .sdaIn(sda)
    );

    i2cSlaveModel #(.targetAddr(7'h48)) i_i2cSlaveModel (
        .FSM_Clk(FSM_Clk), .reset(reset), .scl(scl), .sda(sda), .sdaDriveLow(slaveLow),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .peekAddr(peekAddr), .peekData(peekData)
    );

    always #50 FSM_Clk = ~FSM_Clk;

    // Expected target memory contents, odd multiplier keeps every byte distinct
    function automatic byte_t memPattern(input byte_t addr);
        return (addr * 8'd29) ^ 8'hA5;
    endfunction

    always @(negedge FSM_Clk) begin : compare
        string       name;
        logic [31:0] expVal;
        logic [31:0] actVal;
        while (nameQ.size() > 0) begin
            name = nameQ.pop_front();
            expVal = expQ.pop_front();
            actVal = actQ.pop_front();
            checkCount++;
            if (actVal !== expVal) begin
                $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
                errorCount++;
                testErrors++;
            end
        end
    end

    task automatic queueCheck(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        nameQ.push_back(name);
        expQ.push_back(expVal);
        actQ.push_back(actVal);
    endtask

    task automatic abortRun(input string what);
        $display("Timeout waiting for %s, sequencer state %0d", what,
                 i_i2cMasterTop.i_i2cSequencer.state);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic finishTest(input string name);
        int cycles;
        cycles = 0;
        while (nameQ.size() > 0 && cycles < 4) begin
            @(posedge FSM_Clk);
            cycles++;
        end
        if (nameQ.size() > 0) begin
            abortRun("the compare queue to drain");
        end else begin
            if (testErrors == 0) $display("test %s: ok", name);
            else $display("test %s: %0d errors", name, testErrors);
            testErrors = 0;
        end
    endtask

    task automatic apbAccess(input logic wr, input apbAddr_t addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        int cycles;
        @(posedge FSM_Clk);
        psel <= 1'b1;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge FSM_Clk);
        penable <= 1'b1;
        cycles = 0;
        // Response is sampled mid-cycle in the access phase
        do begin
            @(negedge FSM_Clk);
            cycles++;
        end while (!pready && cycles < apbTimeout);
        if (!pready) begin
            abortRun("APB pready");
        end else begin
            rdata = prdata;
            err = pslverr;
            @(posedge FSM_Clk);
            psel <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apbWrite(input apbAddr_t addr, input logic [31:0] data, output logic err);
        logic [31:0] ignored;
        apbAccess(1'b1, addr, data, ignored, err);
    endtask

    task automatic apbRead(input apbAddr_t addr, output logic [31:0] data);
        logic err;
        apbAccess(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic waitDone(output logic [31:0] status);
        int polls;
        polls = 0;
        status = 32'd0;
        while (!status[1] && polls < doneTimeout) begin
            apbRead(`REG_STATUS, status);
            polls++;
        end
        if (!status[1]) abortRun("STATUS.done");
    endtask

    task automatic runTransaction(input logic readOp, input byte_t regAddr, input byte_t data,
                                  output logic [31:0] status);
        logic err;
        apbWrite(`REG_REGADDR, {24'd0, regAddr}, err);
        apbWrite(`REG_WDATA, {24'd0, data}, err);
        apbWrite(`REG_CTRL, {30'd0, readOp, 1'b1}, err);
        waitDone(status);
    endtask

    task automatic peekModel(input byte_t addr, output byte_t data);
        @(posedge FSM_Clk);
        peekAddr <= addr;
        @(negedge FSM_Clk);
        data = peekData;
    endtask

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] status;
        logic [31:0] rnd;
        logic        err;
        byte_t       addr;
        byte_t       data;
        byte_t       memVal;
        byte_t       lastAddr;
        int          a;
        int          n;
        seed = 75;
        FSM_Clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'd0;
        pwdata = 32'd0;
        loadEn = 1'b0;
        loadAddr = 8'd0;
        loadData = 8'd0;
        peekAddr = 8'd0;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;
        lastAddr = 8'd0;
        for (a = 0; a < 256; a++) begin
            expMem[a] = memPattern(a[7:0]);
        end
        repeat (4) @(posedge FSM_Clk);
        reset <= 1'b0;

        for (a = 0; a < 256; a++) begin
            @(posedge FSM_Clk);
            loadEn <= 1'b1;
            loadAddr <= a[7:0];
            loadData <= expMem[a];
        end
        @(posedge FSM_Clk);
        loadEn <= 1'b0;

        apbRead(`REG_STATUS, rd);
        queueCheck("reset STATUS", 32'd0, rd);
        apbRead(`REG_RDATA, rd);
        queueCheck("reset RDATA", 32'd0, rd);
        queueCheck("reset scl", 32'd1, {31'd0, scl});
        queueCheck("reset sdaDriveLow", 32'd0, {31'd0, masterLow});
        finishTest("reset");

        apbWrite(`REG_DEVADDR, 32'h48, err);
        apbWrite(`REG_REGADDR, 32'h5A, err);
        apbWrite(`REG_WDATA, 32'hC3, err);
        apbRead(`REG_DEVADDR, rd);
        queueCheck("readback DEVADDR", 32'h48, rd);
        apbRead(`REG_REGADDR, rd);
        queueCheck("readback REGADDR", 32'h5A, rd);
        apbRead(`REG_WDATA, rd);
        queueCheck("readback WDATA", 32'hC3, rd);
        finishTest("register readback");

        for (n = 0; n < 4; n++) begin
            rnd = $random(seed);
            addr = rnd[7:0];
            data = rnd[15:8];
            runTransaction(1'b0, addr, data, status);
            queueCheck("write STATUS", 32'd2, status);
            peekModel(addr, memVal);
            queueCheck("write memory", {24'd0, data}, {24'd0, memVal});
            expMem[addr] = data;
            lastAddr = addr;
        end
        finishTest("write transaction");

        // Last pass reads back a location written above
        for (n = 0; n < 5; n++) begin
            rnd = $random(seed);
            addr = (n == 4) ? lastAddr : rnd[7:0];
            runTransaction(1'b1, addr, 8'h00, status);
            queueCheck("read STATUS", 32'd2, status);
            apbRead(`REG_RDATA, rd);
            queueCheck("read RDATA", {24'd0, expMem[addr]}, rd);
        end
        finishTest("read transaction");

        apbWrite(`REG_DEVADDR, 32'h11, err);
        rnd = $random(seed);
        addr = rnd[7:0];
        runTransaction(1'b0, addr, ~expMem[addr], status);
        queueCheck("wrong device STATUS", 32'd6, status);
        peekModel(addr, memVal);
        queueCheck("wrong device memory", {24'd0, expMem[addr]}, {24'd0, memVal});
        apbWrite(`REG_DEVADDR, 32'h48, err);
        finishTest("wrong device");

        rnd = $random(seed);
        addr = rnd[7:0];
        data = rnd[15:8];
        apbWrite(`REG_REGADDR, {24'd0, addr}, err);
        apbWrite(`REG_WDATA, {24'd0, data}, err);
        apbWrite(`REG_CTRL, 32'd1, err);
        queueCheck("busy first start pslverr", 32'd0, {31'd0, err});
        apbWrite(`REG_CTRL, 32'd1, err);
        queueCheck("busy second start pslverr", 32'd1, {31'd0, err});
        waitDone(status);
        queueCheck("busy STATUS", 32'd2, status);
        peekModel(addr, memVal);
        queueCheck("busy memory", {24'd0, data}, {24'd0, memVal});
        expMem[addr] = data;
        finishTest("start while busy");

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/i2cPkg.sv
rtl/apbRegs.sv
rtl/bitTimer.sv
rtl/byteShifter.sv
rtl/i2cSequencer.sv
rtl/i2cMasterTop.sv
verification/i2cSlaveModel.sv
verification/tbI2cMaster.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tbI2cMaster
RTL_TOP   = i2cMasterTop
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o simTop
	./$(OBJ_DIR)/simTop | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
